// ==== Makefile ====
# Verilator build and run of the data cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cache_pkg.sv ====
/* Geometry, address field widths and payload types of the 4-way data cache.
   Every cache module imports it with a wildcard import. */
package cache_pkg;

    // ------------------------------------------------------------------------
    // Geometry.
    // ------------------------------------------------------------------------
    localparam int NUM_WAYS    = 4;
    localparam int SET_COUNT   = 64;
    localparam int WORD_COUNT  = 16;
    localparam int WORD_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 64;
    localparam int REG_WIDTH   = 64;
    localparam int BLOCK_WIDTH = WORD_COUNT * WORD_WIDTH;

    // Byte counts for the store lane logic.
    localparam int WORD_BYTES  = WORD_WIDTH / 8;
    localparam int REG_BYTES   = REG_WIDTH / 8;
    localparam int BLOCK_BYTES = BLOCK_WIDTH / 8;

    // Address fields, lowest first.
    localparam int BYTE_OFFSET_W = $clog2(WORD_BYTES);
    localparam int WORD_OFFSET_W = $clog2(WORD_COUNT);
    localparam int INDEX_W       = $clog2(SET_COUNT);
    localparam int TAG_W         = ADDR_WIDTH - INDEX_W - WORD_OFFSET_W - BYTE_OFFSET_W;
    localparam int WAY_W         = $clog2(NUM_WAYS);

    // ------------------------------------------------------------------------
    // Types.
    // ------------------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [REG_WIDTH-1:0]     reg_t;
    typedef logic [BLOCK_WIDTH-1:0]   block_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [WORD_OFFSET_W-1:0] word_off_t;
    typedef logic [WAY_W-1:0]         way_t;
    typedef logic [WAY_W-1:0]         age_t;

    // Age of the most recently used way.
    localparam age_t AGE_MRU = age_t'(NUM_WAYS - 1);

    typedef enum logic [1:0] {
        ST_BYTE   = 2'd0,
        ST_HALF   = 2'd1,
        ST_WORD   = 2'd2,
        ST_DOUBLE = 2'd3
    } store_type_t;

endpackage

// ==== data_cache.sv ====
/* Top of the 4-way set-associative data cache array.
   Decodes load, store and refill strobes and answers lookups in the same cycle. */
`timescale 1ns/1ps

module data_cache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        arstn,
    input  addr_t       i_addr,
    input  reg_t        i_wdata,
    input  store_type_t i_store_type,
    input  block_t      i_refill_block,
    input  logic        i_load,
    input  logic        i_store,
    input  logic        i_refill,
    output logic        o_hit,
    output reg_t        o_rdata,
    output logic        o_line_valid,
    output logic        o_line_dirty,
    output tag_t        o_line_tag,
    output block_t      o_line_block
);

    tag_t      s_tag;
    index_t    s_index;
    word_off_t s_word_off;

    logic   s_do_store;
    logic   s_do_refill;
    logic   s_do_load;
    logic   s_touch;
    way_t   s_hit_way;
    way_t   s_sel_way;
    way_t   s_victim;
    way_t   s_wr_way;
    block_t s_merged;
    block_t s_data_wentry;

    tag_t   s_way_tags   [NUM_WAYS];
    block_t s_way_blocks [NUM_WAYS];

    // ------------------------------------------------------------------------
    // Address split and command decode.
    // ------------------------------------------------------------------------
    assign s_word_off = word_off_t'(i_addr >> BYTE_OFFSET_W);
    assign s_index    = index_t'(i_addr >> (BYTE_OFFSET_W + WORD_OFFSET_W));
    assign s_tag      = tag_t'(i_addr >> (ADDR_WIDTH - TAG_W));

    // Store beats refill and refill beats load.
    assign s_do_store  = i_store & o_hit;
    assign s_do_refill = i_refill & ~i_store;
    assign s_do_load   = i_load & ~i_store & ~i_refill & o_hit;
    assign s_touch     = s_do_store | s_do_refill | s_do_load;

    // Refill goes to the victim, hits to the matching way.
    assign s_wr_way      = s_do_refill ? s_victim : s_hit_way;
    assign s_data_wentry = s_do_refill ? i_refill_block : s_merged;

    assign o_line_tag   = s_way_tags[s_sel_way];
    assign o_line_block = s_way_blocks[s_sel_way];

    // ------------------------------------------------------------------------
    // Units.
    // ------------------------------------------------------------------------
    way_array #(.T_ENTRY(tag_t)) u_tag_array (
        .clk       (clk),
        .i_index   (s_index),
        .i_we      (s_do_refill),
        .i_way     (s_victim),
        .i_wentry  (s_tag),
        .o_entries (s_way_tags)
    );

    way_array #(.T_ENTRY(block_t)) u_data_array (
        .clk       (clk),
        .i_index   (s_index),
        .i_we      (s_do_store | s_do_refill),
        .i_way     (s_wr_way),
        .i_wentry  (s_data_wentry),
        .o_entries (s_way_blocks)
    );

    line_state u_line_state (
        .clk         (clk),
        .arstn       (arstn),
        .i_index     (s_index),
        .i_tag       (s_tag),
        .i_way_tags  (s_way_tags),
        .i_victim    (s_victim),
        .i_set_dirty (s_do_store),
        .i_refill    (s_do_refill),
        .o_hit       (o_hit),
        .o_hit_way   (s_hit_way),
        .o_sel_way   (s_sel_way),
        .o_valid     (o_line_valid),
        .o_dirty     (o_line_dirty)
    );

    lru_tracker u_lru_tracker (
        .clk         (clk),
        .arstn       (arstn),
        .i_index     (s_index),
        .i_touch     (s_touch),
        .i_touch_way (s_wr_way),
        .o_victim    (s_victim)
    );

    data_lane_unit u_data_lane_unit (
        .i_block      (o_line_block),
        .i_word_off   (s_word_off),
        .i_store_type (i_store_type),
        .i_wdata      (i_wdata),
        .o_rdata      (o_rdata),
        .o_merged     (s_merged)
    );

endmodule

// ==== data_lane_unit.sv ====
/* Load extraction and store merge on one cache block.
   Reads 64 bits from the addressed word and merges SB/SH/SW/SD data into the block. */
`timescale 1ns/1ps

module data_lane_unit
    import cache_pkg::*;
(
    input  block_t      i_block,
    input  word_off_t   i_word_off,
    input  store_type_t i_store_type,
    input  reg_t        i_wdata,
    output reg_t        o_rdata,
    output block_t      o_merged
);

    logic [REG_BYTES-1:0]   s_be_dw;
    logic [BLOCK_BYTES-1:0] s_be_blk;
    block_t                 s_wdata_blk;

    // ------------------------------------------------------------------------
    // Load path.
    // ------------------------------------------------------------------------

    // Zero fill past the end of the block.
    assign o_rdata = reg_t'(i_block >> (i_word_off * WORD_WIDTH));

    // ------------------------------------------------------------------------
    // Store path.
    // ------------------------------------------------------------------------

    // Byte enables relative to the addressed word.
    always_comb begin
        case (i_store_type)
            ST_BYTE: s_be_dw = REG_BYTES'(8'h01);
            ST_HALF: s_be_dw = REG_BYTES'(8'h03);
            ST_WORD: s_be_dw = REG_BYTES'(8'h0f);
            default: s_be_dw = {REG_BYTES{1'b1}};
        endcase
    end

    // Shifting within block width drops bytes beyond the last word.
    assign s_be_blk    = BLOCK_BYTES'(s_be_dw) << (i_word_off * WORD_BYTES);
    assign s_wdata_blk = block_t'(i_wdata) << (i_word_off * WORD_WIDTH);

    always_comb begin
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (s_be_blk[b]) begin
                o_merged[b*8 +: 8] = s_wdata_blk[b*8 +: 8];
            end else begin
                o_merged[b*8 +: 8] = i_block[b*8 +: 8];
            end
        end
    end

endmodule

// ==== line_state.sv ====
/* Valid and dirty bits per line, tag compare and way selection.
   The selected way is the hit way on a hit and the replacement victim otherwise. */
`timescale 1ns/1ps

module line_state
    import cache_pkg::*;
(
    input  logic clk,
    input  logic arstn,
    input  index_t i_index,
    input  tag_t i_tag,
    input  tag_t i_way_tags [NUM_WAYS],
    input  way_t i_victim,
    input  logic i_set_dirty,
    input  logic i_refill,
    output logic o_hit,
    output way_t o_hit_way,
    output way_t o_sel_way,
    output logic o_valid,
    output logic o_dirty
);

    logic [NUM_WAYS-1:0] valid_q [SET_COUNT];
    logic [NUM_WAYS-1:0] dirty_q [SET_COUNT];
    logic [NUM_WAYS-1:0] s_hit_vec;

    // ------------------------------------------------------------------------
    // Lookup.
    // ------------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            s_hit_vec[w] = valid_q[i_index][w] && (i_way_tags[w] == i_tag);
        end
    end

    assign o_hit = |s_hit_vec;

    // At most one way matches a valid tag.
    always_comb begin
        o_hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (s_hit_vec[w]) begin
                o_hit_way = way_t'(w);
            end
        end
    end

    assign o_sel_way = o_hit ? o_hit_way : i_victim;
    assign o_valid   = valid_q[i_index][o_sel_way];
    assign o_dirty   = dirty_q[i_index][o_sel_way];

    // ------------------------------------------------------------------------
    // State update.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q <= '{default: '0};
        end else if (i_refill) begin
            valid_q[i_index][i_victim] <= 1'b1;
        end
    end

    // A refilled line starts clean.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            dirty_q <= '{default: '0};
        end else if (i_refill) begin
            dirty_q[i_index][i_victim] <= 1'b0;
        end else if (i_set_dirty) begin
            dirty_q[i_index][o_hit_way] <= 1'b1;
        end
    end

endmodule

// ==== lru_tracker.sv ====
/* Per-set age counters for LRU replacement.
   The way with age zero is the victim; a touched way becomes the youngest. */
`timescale 1ns/1ps

module lru_tracker
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   arstn,
    input  index_t i_index,
    input  logic   i_touch,
    input  way_t   i_touch_way,
    output way_t   o_victim
);

    age_t ages_q [SET_COUNT][NUM_WAYS];
    age_t s_touch_age;

    assign s_touch_age = ages_q[i_index][i_touch_way];

    // ------------------------------------------------------------------------
    // Victim search.
    // ------------------------------------------------------------------------

    // Ages in a set are a permutation, so exactly one is zero.
    always_comb begin
        o_victim = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (ages_q[i_index][w] == '0) begin
                o_victim = way_t'(w);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Aging.
    // ------------------------------------------------------------------------

    // Ways younger than the touched one step down by one.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    ages_q[s][w] <= age_t'(w);
                end
            end
        end else if (i_touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_t'(w) == i_touch_way) begin
                    ages_q[i_index][w] <= AGE_MRU;
                end else if (ages_q[i_index][w] > s_touch_age) begin
                    ages_q[i_index][w] <= ages_q[i_index][w] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== sources.f ====
cache_pkg.sv
way_array.sv
line_state.sv
lru_tracker.sv
data_lane_unit.sv
data_cache.sv
tb_data_cache.sv

// ==== tb_data_cache.sv ====
/* Directed testbench for the data cache array, checked against a reference model
   of tags, blocks, valid and dirty bits and LRU ages. Compile it with sources.f. */
`timescale 1ns/1ps

module tb_data_cache
    import cache_pkg::*;
();

    localparam int RAND_SEED      = 42;
    localparam int RESET_CYCLES   = 4;
    // The tests take under 100 cycles, so this leaves wide headroom.
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        arstn;
    addr_t       addr;
    reg_t        wdata;
    store_type_t store_type;
    block_t      refill_block;
    logic        load;
    logic        store;
    logic        refill;
    logic        hit;
    reg_t        rdata;
    logic        line_valid;
    logic        line_dirty;
    tag_t        line_tag;
    block_t      line_block;

    // Reference model of the cache state.
    tag_t   m_tag   [SET_COUNT][NUM_WAYS];
    block_t m_block [SET_COUNT][NUM_WAYS];
    logic   m_valid [SET_COUNT][NUM_WAYS];
    logic   m_dirty [SET_COUNT][NUM_WAYS];
    int     m_age   [SET_COUNT][NUM_WAYS];

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    string test_name = "none";
    tag_t  line_a_tag;

    data_cache i_dut (
        .clk            (clk),
        .arstn          (arstn),
        .i_addr         (addr),
        .i_wdata        (wdata),
        .i_store_type   (store_type),
        .i_refill_block (refill_block),
        .i_load         (load),
        .i_store        (store),
        .i_refill       (refill),
        .o_hit          (hit),
        .o_rdata        (rdata),
        .o_line_valid   (line_valid),
        .o_line_dirty   (line_dirty),
        .o_line_tag     (line_tag),
        .o_line_block   (line_block)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Address fields and model rules.
    // ------------------------------------------------------------------------
    function automatic index_t addr_index(addr_t a);
        return a[BYTE_OFFSET_W + WORD_OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_WIDTH-1 -: TAG_W];
    endfunction

    // Byte bits are random since the cache ignores them.
    function automatic addr_t make_addr(tag_t t, index_t idx, int off);
        return {t, idx, word_off_t'(off), 2'($urandom)};
    endfunction

    function automatic tag_t rand_tag();
        return tag_t'({$urandom, $urandom});
    endfunction

    // Random tag whose low nibble tells the lines of one set apart.
    function automatic tag_t marked_tag(int mark);
        tag_t t;
        t = rand_tag();
        t[3:0] = 4'(mark);
        return t;
    endfunction

    function automatic block_t rand_block();
        block_t b;
        for (int i = 0; i < WORD_COUNT; i++) begin
            b[i*32 +: 32] = $urandom;
        end
        return b;
    endfunction

    function automatic bit model_lookup(addr_t a, output int way);
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[addr_index(a)][w] && m_tag[addr_index(a)][w] == addr_tag(a)) begin
                way = w;
            end
        end
        return way >= 0;
    endfunction

    function automatic int model_victim(index_t idx);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_age[idx][w] == 0) begin
                return w;
            end
        end
        return 0;
    endfunction

    function automatic void model_touch(index_t idx, int way);
        int old_age;
        old_age = m_age[idx][way];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) begin
                m_age[idx][w] = NUM_WAYS - 1;
            end else if (m_age[idx][w] > old_age) begin
                m_age[idx][w] = m_age[idx][w] - 1;
            end
        end
    endfunction

    // 64 bits from the addressed word; nothing past the last word.
    function automatic reg_t expected_rdata(block_t blk, int off);
        reg_t r;
        r[31:0] = blk[off*32 +: 32];
        r[63:32] = 32'h0;
        if (off < WORD_COUNT - 1) begin
            r[63:32] = blk[(off+1)*32 +: 32];
        end
        return r;
    endfunction

    function automatic block_t merge_store(block_t blk, int off, store_type_t st, reg_t data);
        int nbytes;
        // Bytes per store: 1, 2, 4, 8.
        nbytes = 1 << int'(st);
        for (int k = 0; k < nbytes; k++) begin
            if (off*4 + k < BLOCK_BYTES) begin
                blk[(off*4 + k)*8 +: 8] = data[k*8 +: 8];
            end
        end
        return blk;
    endfunction

    // ------------------------------------------------------------------------
    // Drive and check.
    // ------------------------------------------------------------------------
    task automatic report_mismatch(string what, block_t exp_val, block_t act_val);
        errors++;
        $display("** Error: test %s, %s expected %0h actual %0h",
                 test_name, what, exp_val, act_val);
    endtask

    task automatic drive(addr_t a, logic ld, logic st, logic rf, store_type_t stype,
                         reg_t wd, block_t blk);
        @(negedge clk);
        addr = a;
        load = ld;
        store = st;
        refill = rf;
        store_type = stype;
        wdata = wd;
        refill_block = blk;
        #1;
    endtask

    task automatic check_outputs(addr_t a);
        int     hw;
        int     sel;
        bit     exp_hit;
        index_t idx;
        idx = addr_index(a);
        exp_hit = model_lookup(a, hw);
        sel = exp_hit ? hw : model_victim(idx);
        checks++;
        if (hit !== exp_hit) report_mismatch("o_hit", block_t'(exp_hit), block_t'(hit));
        if (line_valid !== m_valid[idx][sel]) begin
            report_mismatch("o_line_valid", block_t'(m_valid[idx][sel]), block_t'(line_valid));
        end
        if (line_dirty !== m_dirty[idx][sel]) begin
            report_mismatch("o_line_dirty", block_t'(m_dirty[idx][sel]), block_t'(line_dirty));
        end
        if (m_valid[idx][sel] && line_tag !== m_tag[idx][sel]) begin
            report_mismatch("o_line_tag", block_t'(m_tag[idx][sel]), block_t'(line_tag));
        end
        if (m_valid[idx][sel] && line_block !== m_block[idx][sel]) begin
            report_mismatch("o_line_block", m_block[idx][sel], line_block);
        end
        if (exp_hit && rdata !== expected_rdata(m_block[idx][hw], int'(a[5:2]))) begin
            report_mismatch("o_rdata", block_t'(expected_rdata(m_block[idx][hw],
                            int'(a[5:2]))), block_t'(rdata));
        end
    endtask

    task automatic lookup(addr_t a);
        drive(a, 1'b0, 1'b0, 1'b0, ST_BYTE, '0, '0);
        check_outputs(a);
    endtask

    task automatic load_access(addr_t a);
        int hw;
        drive(a, 1'b1, 1'b0, 1'b0, ST_BYTE, '0, '0);
        check_outputs(a);
        @(posedge clk);
        if (model_lookup(a, hw)) model_touch(addr_index(a), hw);
    endtask

    task automatic store_access(addr_t a, store_type_t st, reg_t wd);
        int hw;
        drive(a, 1'b0, 1'b1, 1'b0, st, wd, '0);
        check_outputs(a);
        @(posedge clk);
        if (model_lookup(a, hw)) begin
            m_block[addr_index(a)][hw] = merge_store(m_block[addr_index(a)][hw],
                                                     int'(a[5:2]), st, wd);
            m_dirty[addr_index(a)][hw] = 1'b1;
            model_touch(addr_index(a), hw);
        end
    endtask

    task automatic refill_line(addr_t a, block_t blk);
        int v;
        drive(a, 1'b0, 1'b0, 1'b1, ST_BYTE, '0, blk);
        check_outputs(a);
        @(posedge clk);
        v = model_victim(addr_index(a));
        m_tag[addr_index(a)][v] = addr_tag(a);
        m_block[addr_index(a)][v] = blk;
        m_valid[addr_index(a)][v] = 1'b1;
        m_dirty[addr_index(a)][v] = 1'b0;
        model_touch(addr_index(a), v);
    endtask

    // ------------------------------------------------------------------------
    // Tests.
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        test_name = "reset_state";
        for (int i = 0; i < 16; i++) begin
            lookup(make_addr(rand_tag(), index_t'($urandom), int'($urandom % 16)));
        end
    endtask

    task automatic test_refill_load();
        test_name = "refill_load";
        line_a_tag = rand_tag();
        refill_line(make_addr(line_a_tag, 6'd5, 0), rand_block());
        for (int off = 0; off < WORD_COUNT; off++) begin
            load_access(make_addr(line_a_tag, 6'd5, off));
        end
        if (rdata[63:32] !== 32'h0) report_mismatch("upper half at offset 15", '0, rdata);
    endtask

    task automatic test_stores();
        store_type_t kinds [8] = '{ST_BYTE, ST_HALF, ST_WORD, ST_DOUBLE,
                                   ST_DOUBLE, ST_BYTE, ST_HALF, ST_WORD};
        int          offs  [8] = '{0, 7, 15, 15, 7, 15, 0, 3};
        test_name = "stores";
        for (int i = 0; i < 8; i++) begin
            store_access(make_addr(line_a_tag, 6'd5, offs[i]), kinds[i], {$urandom, $urandom});
            lookup(make_addr(line_a_tag, 6'd5, offs[i]));
            if (line_dirty !== 1'b1) report_mismatch("dirty after store", 1, line_dirty);
        end
    endtask

    task automatic test_replacement();
        tag_t tags [NUM_WAYS];
        tag_t new_tag;
        tag_t old_tag;
        test_name = "replacement";
        for (int i = 0; i < NUM_WAYS; i++) begin
            tags[i] = marked_tag(i);
            refill_line(make_addr(tags[i], 6'd20, i), rand_block());
        end
        load_access(make_addr(tags[2], 6'd20, 1));
        load_access(make_addr(tags[0], 6'd20, 9));
        load_access(make_addr(tags[3], 6'd20, 4));
        store_access(make_addr(tags[1], 6'd20, 3), ST_WORD, {$urandom, $urandom});
        new_tag = marked_tag(15);
        lookup(make_addr(new_tag, 6'd20, 0));
        old_tag = m_tag[20][model_victim(6'd20)];
        refill_line(make_addr(new_tag, 6'd20, 0), rand_block());
        lookup(make_addr(old_tag, 6'd20, 2));
        if (hit !== 1'b0) report_mismatch("evicted tag hit", 0, hit);
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup(make_addr(m_tag[20][w], 6'd20, w));
            if (hit !== 1'b1) report_mismatch("remaining way hit", 1, hit);
        end
    endtask

    task automatic test_miss_and_dirty_victim();
        tag_t miss_tag;
        int   v;
        test_name = "miss_no_change";
        miss_tag = marked_tag(10);
        store_access(make_addr(miss_tag, 6'd20, 4), ST_DOUBLE, {$urandom, $urandom});
        load_access(make_addr(miss_tag, 6'd20, 2));
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup(make_addr(m_tag[20][w], 6'd20, w + 5));
        end
        lookup(make_addr(miss_tag, 6'd20, 0));

        // Dirty the victim, then touch the others so it is the victim again.
        test_name = "dirty_victim";
        v = model_victim(6'd20);
        store_access(make_addr(m_tag[20][v], 6'd20, 0), ST_BYTE, {$urandom, $urandom});
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w != v) load_access(make_addr(m_tag[20][w], 6'd20, 8));
        end
        lookup(make_addr(miss_tag, 6'd20, 0));
        if (line_dirty !== 1'b1) report_mismatch("victim dirty", 1, line_dirty);
        refill_line(make_addr(miss_tag, 6'd20, 0), rand_block());
        lookup(make_addr(miss_tag, 6'd20, 0));
        if (hit !== 1'b1 || line_dirty !== 1'b0) report_mismatch("new line clean", 0, line_dirty);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        clk = 1'b0;
        arstn = 1'b0;
        addr = '0;
        wdata = '0;
        store_type = ST_BYTE;
        refill_block = '0;
        load = 1'b0;
        store = 1'b0;
        refill = 1'b0;
        for (int s = 0; s < SET_COUNT; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w] = w;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;

        test_reset_state();
        test_refill_load();
        test_stores();
        test_replacement();
        test_miss_and_dirty_victim();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== way_array.sv ====
/* Set by way storage for one payload type, used for both tags and blocks.
   All ways of a set are read at once; one entry is written per clock edge. */
`timescale 1ns/1ps

module way_array
    import cache_pkg::*;
#(
    parameter type T_ENTRY = tag_t
)(
    input  logic   clk,
    input  index_t i_index,
    input  logic   i_we,
    input  way_t   i_way,
    input  T_ENTRY i_wentry,
    output T_ENTRY o_entries [NUM_WAYS]
);

    // Storage, no reset.
    T_ENTRY mem [SET_COUNT][NUM_WAYS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index][i_way] <= i_wentry;
        end
    end

    // Whole set is visible in the same cycle.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            o_entries[w] = mem[i_index][w];
        end
    end

endmodule
